// ==== sim.f ====
+incdir+src
src/load_unit_pkg.sv
src/load_decode.sv
src/load_ctrl.sv
src/load_buffer.sv
src/load_result.sv
src/load_unit.sv
dv/dcache_model.sv
dv/tb_load_unit.sv

// ==== run.sh ====
#!/bin/sh
# build the load unit testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing \
  -f sim.f \
  --top-module tb_load_unit \
  -o tb_load_unit_sim \
  && ./obj_dir/tb_load_unit_sim | tee /dev/stderr | grep -q "Simulation PASSED" \
  && echo "run.sh: pass" \
  || { echo "run.sh: fail"; exit 1; }

// ==== dv/tb_load_unit.sv ====
// load unit testbench
// directed tests for alignment, grant stalls, page offset hold,
// back to back loads and flush, checked against the memory pattern
`default_nettype none

`include "load_unit_defs.svh"

module tb_load_unit;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int NUM_LOADS = 47;

  logic                        clk_i = 1'b0;
  logic                        rst_ni;
  logic                        flush_i;
  logic                        valid_i;
  load_unit_pkg::lsu_req_t     lsu_req_i;
  logic                        pop_ld_o;
  logic [`LU_INDEX_W-1:0]      page_offset_o;
  logic                        page_offset_matches_i;
  load_unit_pkg::dcache_req_t  dcache_req;
  load_unit_pkg::dcache_rsp_t  dcache_rsp;
  logic                        valid_o;
  load_unit_pkg::load_result_t result_o;

  logic [31:0]                 lfsr = 32'hd6da9f3d;
  logic [2:0]                  next_id = '0;
  logic                        pending [8];
  logic [31:0]                 exp_addr [8];
  load_unit_pkg::lu_op_e       exp_op [8];
  // transaction id of the load granted into each cache request id
  logic [2:0]                  slot_tid [`LU_NR_LDBUF];

  always #2 clk_i = ~clk_i;

  load_unit uut (
    .clk_i, .rst_ni, .flush_i, .valid_i, .lsu_req_i, .pop_ld_o, .page_offset_o,
    .page_offset_matches_i, .dcache_req_o(dcache_req), .dcache_rsp_i(dcache_rsp),
    .valid_o, .result_o
  );

  dcache_model u_dcache (.clk_i, .rst_ni, .req_i(dcache_req), .rsp_o(dcache_rsp));

  // ---------------------------------------------------------------------------
  // helpers
  // ---------------------------------------------------------------------------
  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Simulation FAILED");
    $fatal(1);
  endtask

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v    = {v[30:0], lfsr[0]};
      lfsr = {1'b0, lfsr[31:1]} ^ (lfsr[0] ? 32'h8020_0003 : 32'h0);
    end
    return v;
  endfunction

  // bytes read by one load operation
  function automatic int op_bytes(input load_unit_pkg::lu_op_e op);
    case (op)
      load_unit_pkg::LW, load_unit_pkg::LWU: return 4;
      load_unit_pkg::LH, load_unit_pkg::LHU: return 2;
      load_unit_pkg::LB, load_unit_pkg::LBU: return 1;
      default:                               return 8;
    endcase
  endfunction

  // bytes from the pattern at addr, extended as the op says
  function automatic logic [63:0] expected_data(input logic [31:0] addr,
                                                input load_unit_pkg::lu_op_e op);
    logic [63:0] v;
    int          n;
    logic        sext;
    v    = '0;
    n    = op_bytes(op);
    sext = op inside {load_unit_pkg::LW, load_unit_pkg::LH, load_unit_pkg::LB};
    for (int i = 0; i < n; i++) begin
      v[i*8+:8] = {addr[7:3], addr[2:0] + 3'(i)} ^ 8'h5a;
    end
    if (sext && n < 8 && v[n*8-1]) begin
      v = v | (64'hffff_ffff_ffff_ffff << (n * 8));
    end
    return v;
  endfunction

  // index, enables and size the cache must see for a load
  function automatic load_unit_pkg::dcache_req_t expected_request(
      input logic [31:0] addr, input load_unit_pkg::lu_op_e op);
    load_unit_pkg::dcache_req_t r;
    int                         n;
    r               = '0;
    n               = op_bytes(op);
    r.address_index = addr[11:0];
    r.data_be       = 8'(((1 << n) - 1) << addr[2:0]);
    r.data_size     = (n == 8) ? 2'b11 : (n == 4) ? 2'b10 : (n == 2) ? 2'b01 : 2'b00;
    return r;
  endfunction

  task automatic compare_result(input load_unit_pkg::load_result_t got,
                                input load_unit_pkg::load_result_t exp);
    if (got.trans_id !== exp.trans_id) begin
      $display("CHECK FAILED result_o.trans_id got %h exp %h", got.trans_id, exp.trans_id);
      fail_run("result has the wrong transaction id");
    end
    if (got.data !== exp.data) begin
      $display("CHECK FAILED result_o.data got %h exp %h", got.data, exp.data);
      fail_run("result has the wrong data");
    end
  endtask

  task automatic compare_offset(input logic [11:0] got, input logic [11:0] exp);
    if (got !== exp) begin
      $display("CHECK FAILED page_offset_o got %h exp %h", got, exp);
      fail_run("page offset does not match the request");
    end
  endtask

  task automatic compare_request(input load_unit_pkg::dcache_req_t got,
                                 input load_unit_pkg::dcache_req_t exp);
    if (got.address_index !== exp.address_index) begin
      $display("CHECK FAILED dcache_req_o.address_index got %h exp %h",
               got.address_index, exp.address_index);
      fail_run("cache index does not match the request");
    end
    if (got.data_be !== exp.data_be) begin
      $display("CHECK FAILED dcache_req_o.data_be got %h exp %h", got.data_be, exp.data_be);
      fail_run("byte enables do not match the load");
    end
    if (got.data_size !== exp.data_size) begin
      $display("CHECK FAILED dcache_req_o.data_size got %h exp %h",
               got.data_size, exp.data_size);
      fail_run("transfer size does not match the load");
    end
  endtask

  // ---------------------------------------------------------------------------
  // monitor of pops and results
  // ---------------------------------------------------------------------------
  always @(posedge clk_i) begin
    int n;
    logic [2:0] tid;
    load_unit_pkg::load_result_t exp;
    n = 0;
    if (rst_ni && pop_ld_o && !valid_i) fail_run("pop without a request");
    if (rst_ni && valid_o) begin
      // response id leads to the slot and the slot to the load
      tid = slot_tid[dcache_rsp.data_rid];
      if (!pending[tid]) fail_run("result for a load not in flight");
      exp.trans_id = tid;
      exp.data = expected_data(exp_addr[tid], exp_op[tid]);
      compare_result(result_o, exp);
      pending[tid] = 1'b0;
    end
    for (int i = 0; i < 8; i++) n += int'(pending[i]);
    if (n > `LU_NR_LDBUF) fail_run("more than four loads outstanding");
  end

  // request already driven, wait for its pop
  task automatic wait_pop(input logic [2:0] id, input logic [31:0] addr,
                          input load_unit_pkg::lu_op_e op);
    int                        cycles;
    logic [`LU_LDBUF_ID_W-1:0] slot;
    cycles = 0;
    slot   = '0;
    forever begin
      @(posedge clk_i);
      compare_offset(page_offset_o, addr[11:0]);
      if (pop_ld_o) begin
        compare_request(dcache_req, expected_request(addr, op));
        slot = dcache_req.data_id;
        break;
      end
      cycles++;
      if (cycles > 200) fail_run("no grant for a load request");
    end
    #1;
    valid_i        = 1'b0;
    slot_tid[slot] = id;
    exp_addr[id]   = addr;
    exp_op[id]     = op;
    pending[id]    = 1'b1;
  endtask

  task automatic drive_load(input logic [31:0] addr, input load_unit_pkg::lu_op_e op,
                            output logic [2:0] id);
    id = next_id;
    next_id++;
    if (pending[id]) fail_run("transaction id reused while in flight");
    valid_i            = 1'b1;
    lsu_req_i.trans_id = id;
    lsu_req_i.vaddr    = addr;
    lsu_req_i.op       = op;
  endtask

  task automatic issue_load(input logic [31:0] addr, input load_unit_pkg::lu_op_e op);
    logic [2:0] id;
    drive_load(addr, op, id);
    wait_pop(id, addr, op);
  endtask

  task automatic wait_idle();
    int cycles;
    logic busy;
    cycles = 0;
    do begin
      @(posedge clk_i);
      #1;
      busy = 1'b0;
      for (int i = 0; i < 8; i++) busy |= pending[i];
      cycles++;
      if (cycles > 200) fail_run("loads never retired");
    end while (busy);
  endtask

  // ---------------------------------------------------------------------------
  // tests
  // ---------------------------------------------------------------------------
  task automatic test_alignment();
    load_unit_pkg::lu_op_e op;
    int step;
    for (int k = 0; k < 7; k++) begin
      op   = load_unit_pkg::lu_op_e'(k);
      step = (k == 0) ? 8 : (k < 3) ? 4 : (k < 5) ? 2 : 1;
      for (int off = 0; off < 8; off += step) begin
        issue_load(32'h1234_5000 + 32'(k * 72) + 32'(off), op);
      end
    end
    wait_idle();
  endtask

  task automatic test_random_stalls();
    load_unit_pkg::lu_op_e op;
    logic [31:0]           addr;
    for (int i = 0; i < 8; i++) begin
      op   = load_unit_pkg::lu_op_e'(rand_bits(3) % 7);
      // keep the access naturally aligned
      addr = rand_bits(32) & ~(32'(op_bytes(op)) - 32'd1);
      issue_load(addr, op);
    end
    wait_idle();
  endtask

  task automatic test_page_hold();
    logic [2:0] id;
    page_offset_matches_i = 1'b1;
    drive_load(32'h0000_2a3c, load_unit_pkg::LW, id);
    repeat (8) begin
      @(posedge clk_i);
      if (pop_ld_o) fail_run("pop while a store hit the same page offset");
    end
    #1;
    page_offset_matches_i = 1'b0;
    wait_pop(id, 32'h0000_2a3c, load_unit_pkg::LW);
    wait_idle();
  endtask

  task automatic test_back_to_back();
    for (int i = 0; i < 6; i++) begin
      issue_load(32'h4000_0100 + 32'(i * 14), load_unit_pkg::LHU);
    end
    wait_idle();
  endtask

  task automatic test_flush();
    issue_load(32'h5555_0008, load_unit_pkg::LD);
    issue_load(32'h5555_0013, load_unit_pkg::LB);
    flush_i = 1'b1;
    @(posedge clk_i);
    #1;
    flush_i = 1'b0;
    // anything still in flight must now stay silent
    for (int i = 0; i < 8; i++) pending[i] = 1'b0;
    issue_load(32'h5555_0026, load_unit_pkg::LH);
    wait_idle();
    repeat (10) @(posedge clk_i);
    #1;
  endtask

  initial begin
    #(NUM_LOADS * 40 + 400);
    fail_run("watchdog timeout, the run took too long");
  end

  initial begin
    for (int i = 0; i < 8; i++) pending[i] = 1'b0;
    for (int i = 0; i < `LU_NR_LDBUF; i++) slot_tid[i] = '0;
    rst_ni                = 1'b0;
    flush_i               = 1'b0;
    valid_i               = 1'b0;
    lsu_req_i             = '0;
    page_offset_matches_i = 1'b0;
    repeat (2) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    @(posedge clk_i);
    #1;
    test_alignment();
    test_random_stalls();
    test_page_hold();
    test_back_to_back();
    test_flush();
    $display("Simulation PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== dv/dcache_model.sv ====
// data cache model
// grants with random stalls, takes the tag one cycle later and answers
// each surviving request after 1 to 4 cycles, possibly out of order
`default_nettype none

`include "load_unit_defs.svh"

module dcache_model (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  load_unit_pkg::dcache_req_t req_i,
  output load_unit_pkg::dcache_rsp_t rsp_o
);
  timeunit 1ns;
  timeprecision 100ps;

  logic [31:0]                     lfsr_q;
  logic                            go_q;
  // request granted last cycle, waiting for its tag
  logic                            acc_q;
  logic [`LU_LDBUF_ID_W-1:0]       acc_id_q;
  logic [`LU_INDEX_W-1:0]          acc_index_q;
  logic                            pend_v [`LU_NR_LDBUF];
  logic [2:0]                      pend_cnt [`LU_NR_LDBUF];
  logic [`LU_PLEN-1:0]             pend_addr [`LU_NR_LDBUF];
  logic                            rvalid_q;
  logic [`LU_LDBUF_ID_W-1:0]       rid_q;
  logic [`LU_XLEN-1:0]             rdata_q;

  // galois step, taps of x^32+x^22+x^2+x+1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {1'b0, s[31:1]} ^ (s[0] ? 32'h8020_0003 : 32'h0);
  endfunction

  // every byte is its own address low byte xor 5a
  function automatic logic [63:0] word_at(input logic [31:0] addr);
    logic [63:0] w;
    for (int i = 0; i < 8; i++) begin
      w[i*8+:8] = {addr[7:3], 3'(i)} ^ 8'h5a;
    end
    return w;
  endfunction

  always_comb begin
    rsp_o.data_gnt    = req_i.data_req && go_q;
    rsp_o.data_rvalid = rvalid_q;
    rsp_o.data_rid    = rid_q;
    rsp_o.data_rdata  = rdata_q;
  end

  always @(posedge clk_i or negedge rst_ni) begin
    logic [31:0] l;
    logic        found;
    if (!rst_ni) begin
      lfsr_q   <= 32'hd6da9f3d;
      go_q     <= 1'b0;
      acc_q    <= 1'b0;
      rvalid_q <= 1'b0;
      rid_q    <= '0;
      rdata_q  <= '0;
      for (int i = 0; i < `LU_NR_LDBUF; i++) begin
        pend_v[i] = 1'b0;
      end
    end else begin
      l     = lfsr_q;
      found = 1'b0;
      rvalid_q <= 1'b0;
      // one response per cycle, lowest ready slot first
      for (int i = 0; i < `LU_NR_LDBUF; i++) begin
        if (pend_v[i] && pend_cnt[i] == 0 && !found) begin
          found     = 1'b1;
          pend_v[i] = 1'b0;
          rvalid_q <= 1'b1;
          rid_q    <= i[`LU_LDBUF_ID_W-1:0];
          rdata_q  <= word_at(pend_addr[i]);
        end else if (pend_v[i] && pend_cnt[i] != 0) begin
          pend_cnt[i] = pend_cnt[i] - 3'd1;
        end
      end
      // tag cycle, a killed request is dropped silently
      if (acc_q && req_i.tag_valid && !req_i.kill_req) begin
        pend_v[acc_id_q]    = 1'b1;
        pend_addr[acc_id_q] = {req_i.address_tag, acc_index_q};
        pend_cnt[acc_id_q]  = {1'b0, l[1:0]};
        l = lfsr_step(lfsr_step(l));
      end
      acc_q       <= req_i.data_req && rsp_o.data_gnt;
      acc_id_q    <= req_i.data_id;
      acc_index_q <= req_i.address_index;
      // grant stall for the next cycle
      go_q   <= l[0];
      lfsr_q <= lfsr_step(l);
    end
  end

endmodule

`default_nettype wire

// ==== src/load_unit.sv ====
// load unit
// takes one load at a time from the issue queue, sends it to the data
// cache, tracks up to four outstanding loads and retires realigned data
`default_nettype none

`include "load_unit_defs.svh"

module load_unit (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         flush_i,
  input  logic                         valid_i,
  input  load_unit_pkg::lsu_req_t      lsu_req_i,
  output logic                         pop_ld_o,
  output logic [`LU_INDEX_W-1:0]       page_offset_o,
  input  logic                         page_offset_matches_i,
  output load_unit_pkg::dcache_req_t   dcache_req_o,
  input  load_unit_pkg::dcache_rsp_t   dcache_rsp_i,
  output logic                         valid_o,
  output load_unit_pkg::load_result_t  result_o
);

  load_unit_pkg::dcache_req_t  dec_req;
  load_unit_pkg::ldbuf_entry_t dec_entry;
  load_unit_pkg::ldbuf_entry_t rd_entry;
  logic [`LU_TAG_W-1:0]        tag_q;
  logic                        data_req;
  logic                        tag_valid;
  logic                        kill_req;
  logic                        ldbuf_w;
  logic                        ldbuf_full;
  logic [`LU_LDBUF_ID_W-1:0]   ldbuf_windex;
  logic                        rd_drop;

  load_decode u_decode (
    .lsu_req_i     (lsu_req_i),
    .tag_q_i       (tag_q),
    .cache_req_o   (dec_req),
    .entry_o       (dec_entry),
    .page_offset_o (page_offset_o)
  );

  // tag bits sit right above the index
  load_ctrl u_ctrl (
    .clk_i                 (clk_i),
    .rst_ni                (rst_ni),
    .flush_i               (flush_i),
    .valid_i               (valid_i),
    .page_offset_matches_i (page_offset_matches_i),
    .ldbuf_full_i          (ldbuf_full),
    .data_gnt_i            (dcache_rsp_i.data_gnt),
    .vaddr_tag_i           (lsu_req_i.vaddr[`LU_INDEX_W+`LU_TAG_W-1:`LU_INDEX_W]),
    .data_req_o            (data_req),
    .tag_valid_o           (tag_valid),
    .kill_req_o            (kill_req),
    .pop_ld_o              (pop_ld_o),
    .ldbuf_w_o             (ldbuf_w),
    .tag_q_o               (tag_q)
  );

  load_buffer u_buffer (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .flush_i  (flush_i),
    .w_i      (ldbuf_w),
    .entry_i  (dec_entry),
    .r_i      (dcache_rsp_i.data_rvalid),
    .rid_i    (dcache_rsp_i.data_rid),
    .kill_i   (kill_req),
    .full_o   (ldbuf_full),
    .windex_o (ldbuf_windex),
    .rentry_o (rd_entry),
    .rdrop_o  (rd_drop)
  );

  load_result u_result (
    .rvalid_i (dcache_rsp_i.data_rvalid),
    .rdrop_i  (rd_drop),
    .rentry_i (rd_entry),
    .rdata_i  (dcache_rsp_i.data_rdata),
    .valid_o  (valid_o),
    .result_o (result_o)
  );

  // cache request, the slot index doubles as request id
  always_comb begin
    dcache_req_o           = dec_req;
    dcache_req_o.data_req  = data_req;
    dcache_req_o.tag_valid = tag_valid;
    dcache_req_o.kill_req  = kill_req;
    dcache_req_o.data_id   = ldbuf_windex;
  end

endmodule

`default_nettype wire

// ==== src/load_result.sv ====
// load result
// realigns the returned word to the load offset, extends it to 64 bits
// and passes it on unless the load was flushed or killed
`default_nettype none

`include "load_unit_defs.svh"

module load_result (
  input  logic                         rvalid_i,
  input  logic                         rdrop_i,
  input  load_unit_pkg::ldbuf_entry_t  rentry_i,
  input  logic [`LU_XLEN-1:0]          rdata_i,
  output logic                         valid_o,
  output load_unit_pkg::load_result_t  result_o
);

  logic [`LU_XLEN-1:0]       shifted;
  logic [`LU_XLEN/8-1:0]     sign_bits;
  logic [`LU_XLEN_ALIGN-1:0] sign_byte;
  logic                      is_signed;
  logic                      sign_bit;

  assign valid_o = rvalid_i && !rdrop_i;

  // move the addressed bytes down to bit 0
  assign shifted = rdata_i >> {rentry_i.offset, 3'b000};

  // msb of every byte, one of them is the sign
  for (genvar i = 0; i < `LU_XLEN / 8; i++) begin : gen_sign_bits
    assign sign_bits[i] = rdata_i[i*8+7];
  end

  assign is_signed = rentry_i.op inside {load_unit_pkg::LW, load_unit_pkg::LH,
                                         load_unit_pkg::LB};

  // top byte of the loaded width, picked next to the shifter
  always_comb begin
    case (rentry_i.op)
      load_unit_pkg::LW: sign_byte = rentry_i.offset + 3'd3;
      load_unit_pkg::LH: sign_byte = rentry_i.offset + 3'd1;
      default:           sign_byte = rentry_i.offset;
    endcase
  end

  // zero for unsigned loads
  assign sign_bit = is_signed && sign_bits[sign_byte];

  always_comb begin
    result_o.trans_id = rentry_i.trans_id;
    case (rentry_i.op)
      load_unit_pkg::LW, load_unit_pkg::LWU:
        result_o.data = {{(`LU_XLEN - 32){sign_bit}}, shifted[31:0]};
      load_unit_pkg::LH, load_unit_pkg::LHU:
        result_o.data = {{(`LU_XLEN - 16){sign_bit}}, shifted[15:0]};
      load_unit_pkg::LB, load_unit_pkg::LBU:
        result_o.data = {{(`LU_XLEN - 8){sign_bit}}, shifted[7:0]};
      default:
        result_o.data = shifted;
    endcase
  end

endmodule

`default_nettype wire

// ==== src/load_buffer.sv ====
// load buffer
// table of loads sent to the data cache, indexed by the cache request id,
// with free slot search, flush marking and lookup of returning responses
`default_nettype none

`include "load_unit_defs.svh"

module load_buffer (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         flush_i,
  input  logic                         w_i,
  input  load_unit_pkg::ldbuf_entry_t  entry_i,
  input  logic                         r_i,
  input  logic [`LU_LDBUF_ID_W-1:0]    rid_i,
  input  logic                         kill_i,
  output logic                         full_o,
  output logic [`LU_LDBUF_ID_W-1:0]    windex_o,
  output load_unit_pkg::ldbuf_entry_t  rentry_o,
  output logic                         rdrop_o
);

  logic [`LU_NR_LDBUF-1:0]     valid_d, valid_q;
  logic [`LU_NR_LDBUF-1:0]     flushed_d, flushed_q;
  load_unit_pkg::ldbuf_entry_t mem_q [`LU_NR_LDBUF];
  logic [`LU_LDBUF_ID_W-1:0]   windex;
  logic [`LU_LDBUF_ID_W-1:0]   last_id_q;
  // high in the tag cycle of the slot written last
  logic                        w_q;

  assign full_o = &valid_q;

  // lowest free slot, the top slot wins only if all others are taken
  always_comb begin
    windex = '0;
    for (int i = `LU_NR_LDBUF - 1; i >= 0; i--) begin
      if (!valid_q[i]) begin
        windex = i[`LU_LDBUF_ID_W-1:0];
      end
    end
  end

  assign windex_o = windex;

  // ---------------------------------------------------------------------------
  // slot state
  // ---------------------------------------------------------------------------
  always_comb begin
    valid_d   = valid_q;
    flushed_d = flushed_q;
    // all loads in flight belong to squashed instructions
    if (flush_i) begin
      flushed_d = '1;
    end
    // response returned, slot is free again
    if (r_i) begin
      valid_d[rid_i] = 1'b0;
    end
    // a killed request never gets a response
    if (kill_i && w_q) begin
      valid_d[last_id_q] = 1'b0;
    end
    if (w_i) begin
      valid_d[windex]   = 1'b1;
      flushed_d[windex] = 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q   <= '0;
      flushed_q <= '0;
      last_id_q <= '0;
      w_q       <= 1'b0;
    end else begin
      valid_q   <= valid_d;
      flushed_q <= flushed_d;
      w_q       <= w_i;
      if (w_i) begin
        last_id_q <= windex;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (w_i) begin
      mem_q[windex] <= entry_i;
    end
  end

  // ---------------------------------------------------------------------------
  // response lookup
  // ---------------------------------------------------------------------------
  assign rentry_o = mem_q[rid_i];
  // flushed, or the request killed in this very cycle
  assign rdrop_o  = flushed_q[rid_i] || (kill_i && (last_id_q == rid_i));

endmodule

`default_nettype wire

// ==== src/load_ctrl.sv ====
// load control
// FSM that issues the index request, waits for the grant, sends the
// tag one cycle later and kills the tag cycle on a flush
`default_nettype none

`include "load_unit_defs.svh"

module load_ctrl (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 flush_i,
  input  logic                 valid_i,
  input  logic                 page_offset_matches_i,
  input  logic                 ldbuf_full_i,
  input  logic                 data_gnt_i,
  input  logic [`LU_TAG_W-1:0] vaddr_tag_i,
  output logic                 data_req_o,
  output logic                 tag_valid_o,
  output logic                 kill_req_o,
  output logic                 pop_ld_o,
  output logic                 ldbuf_w_o,
  output logic [`LU_TAG_W-1:0] tag_q_o
);

  typedef enum logic [2:0] {
    IDLE,
    WAIT_PAGE_OFFSET,
    WAIT_GNT,
    SEND_TAG,
    WAIT_FLUSH
  } state_e;

  state_e               state_d, state_q;
  logic                 accept_req;
  logic                 can_start;
  logic [`LU_TAG_W-1:0] tag_q;

  // a request can start when it is there and a slot is free
  assign accept_req = valid_i && !ldbuf_full_i;
  // a new index can go out when idle or alongside a tag
  assign can_start  = (state_q == IDLE) || (state_q == SEND_TAG);

  // ---------------------------------------------------------------------------
  // next state and cache strobes
  // ---------------------------------------------------------------------------
  always_comb begin
    state_d     = state_q;
    data_req_o  = 1'b0;
    tag_valid_o = 1'b0;
    kill_req_o  = 1'b0;
    pop_ld_o    = 1'b0;

    case (state_q)
      // a store to the same page offset is pending, hold the load
      WAIT_PAGE_OFFSET: begin
        if (!page_offset_matches_i) begin
          state_d = WAIT_GNT;
        end
      end
      // keep the request up until the cache takes it
      WAIT_GNT: begin
        data_req_o = 1'b1;
        if (data_gnt_i) begin
          pop_ld_o = 1'b1;
          state_d  = SEND_TAG;
        end
      end
      // tag of the request granted in the last cycle
      SEND_TAG: begin
        tag_valid_o = 1'b1;
        state_d     = IDLE;
      end
      // drop whatever request got its grant before the flush
      WAIT_FLUSH: begin
        tag_valid_o = 1'b1;
        kill_req_o  = 1'b1;
        state_d     = IDLE;
      end
      default: begin
        state_d = IDLE;
      end
    endcase

    // start of a new load, back to back behind a tag cycle too
    if (can_start && accept_req) begin
      if (page_offset_matches_i) begin
        state_d = WAIT_PAGE_OFFSET;
      end else begin
        data_req_o = 1'b1;
        if (data_gnt_i) begin
          pop_ld_o = 1'b1;
          state_d  = SEND_TAG;
        end else begin
          state_d = WAIT_GNT;
        end
      end
    end

    // flush wins over everything else
    if (flush_i) begin
      state_d = WAIT_FLUSH;
    end
  end

  // a granted request takes a buffer slot
  assign ldbuf_w_o = data_req_o && data_gnt_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // tag is held for the cycle after the grant
  always_ff @(posedge clk_i) begin
    if (ldbuf_w_o) begin
      tag_q <= vaddr_tag_i;
    end
  end

  assign tag_q_o = tag_q;

endmodule

`default_nettype wire

// ==== src/load_decode.sv ====
// load request decode
// splits the load address into cache index and page offset, derives
// transfer size and byte enables, and forms the load buffer entry
`default_nettype none

`include "load_unit_defs.svh"

module load_decode (
  input  load_unit_pkg::lsu_req_t     lsu_req_i,
  input  logic [`LU_TAG_W-1:0]        tag_q_i,
  output load_unit_pkg::dcache_req_t  cache_req_o,
  output load_unit_pkg::ldbuf_entry_t entry_o,
  output logic [`LU_INDEX_W-1:0]      page_offset_o
);

  logic [`LU_XLEN_ALIGN-1:0] offset;
  logic [1:0]                size;
  logic [`LU_XLEN/8-1:0]     be_mask;

  assign offset = lsu_req_i.vaddr[`LU_XLEN_ALIGN-1:0];

  // size code 3 is a double word, 0 a single byte
  always_comb begin
    case (lsu_req_i.op)
      load_unit_pkg::LW, load_unit_pkg::LWU: size = 2'b10;
      load_unit_pkg::LH, load_unit_pkg::LHU: size = 2'b01;
      load_unit_pkg::LB, load_unit_pkg::LBU: size = 2'b00;
      default:                               size = 2'b11;
    endcase
  end

  // enables of an aligned access, moved up to the byte offset
  always_comb begin
    case (size)
      2'b00:   be_mask = 8'h01;
      2'b01:   be_mask = 8'h03;
      2'b10:   be_mask = 8'h0f;
      default: be_mask = 8'hff;
    endcase
  end

  // only index, tag, enables and size come from here
  // the strobes and the id are filled in at the top
  always_comb begin
    cache_req_o               = '0;
    cache_req_o.address_index = lsu_req_i.vaddr[`LU_INDEX_W-1:0];
    // tag belongs to the load granted one cycle earlier
    cache_req_o.address_tag   = tag_q_i;
    cache_req_o.data_be       = be_mask << offset;
    cache_req_o.data_size     = size;
  end

  // what is needed to retire the load later
  assign entry_o.trans_id = lsu_req_i.trans_id;
  assign entry_o.offset   = offset;
  assign entry_o.op       = lsu_req_i.op;

  // page offset for the store unit address check
  assign page_offset_o = lsu_req_i.vaddr[`LU_INDEX_W-1:0];

endmodule

`default_nettype wire

// ==== src/load_unit_pkg.sv ====
// load unit types
// load operation encoding and the packed structs that travel between
// the issue queue, the load unit blocks and the data cache
`default_nettype none

`include "load_unit_defs.svh"

package load_unit_pkg;

  // load operations, signed and unsigned variants
  typedef enum logic [2:0] {
    LD,
    LW,
    LWU,
    LH,
    LHU,
    LB,
    LBU
  } lu_op_e;

  // request as it sits at the head of the issue queue
  typedef struct packed {
    logic [`LU_TRANS_ID_W-1:0] trans_id;
    logic [`LU_PLEN-1:0]       vaddr;
    lu_op_e                    op;
  } lsu_req_t;

  // one outstanding load, enough to realign and retire its data
  typedef struct packed {
    logic [`LU_TRANS_ID_W-1:0] trans_id;
    // byte position of the load inside the word
    logic [`LU_XLEN_ALIGN-1:0] offset;
    lu_op_e                    op;
  } ldbuf_entry_t;

  // request port toward the data cache
  typedef struct packed {
    logic [`LU_INDEX_W-1:0]    address_index;
    logic [`LU_TAG_W-1:0]      address_tag;
    logic                      data_req;
    logic                      tag_valid;
    logic                      kill_req;
    logic [`LU_XLEN/8-1:0]     data_be;
    logic [1:0]                data_size;
    // id returned with the response, the buffer slot
    logic [`LU_LDBUF_ID_W-1:0] data_id;
  } dcache_req_t;

  // response port from the data cache
  typedef struct packed {
    logic                      data_gnt;
    logic                      data_rvalid;
    logic [`LU_LDBUF_ID_W-1:0] data_rid;
    logic [`LU_XLEN-1:0]       data_rdata;
  } dcache_rsp_t;

  // retired load toward the scoreboard
  typedef struct packed {
    logic [`LU_TRANS_ID_W-1:0] trans_id;
    logic [`LU_XLEN-1:0]       data;
  } load_result_t;

endpackage

`default_nettype wire

// ==== src/load_unit_defs.svh ====
// load unit configuration
// data path width, cache address split, scoreboard id width
// and depth of the outstanding load table
`ifndef LOAD_UNIT_DEFS_SVH
`define LOAD_UNIT_DEFS_SVH

// ---------------------------------------------------------------------------
// data path
// ---------------------------------------------------------------------------
// width of one loaded word
`define LU_XLEN 64
// bits of byte offset inside one word
`define LU_XLEN_ALIGN 3

// ---------------------------------------------------------------------------
// cache addressing
// ---------------------------------------------------------------------------
// physical address width, equal to the virtual one here
`define LU_PLEN 32
// index part, this is the 4 KiB page offset
`define LU_INDEX_W 12
// tag part, sent one cycle after the index
`define LU_TAG_W 20

// ---------------------------------------------------------------------------
// bookkeeping
// ---------------------------------------------------------------------------
// scoreboard transaction id
`define LU_TRANS_ID_W 3
// outstanding loads and width of an index into them
`define LU_NR_LDBUF 4
`define LU_LDBUF_ID_W 2

`endif
